// ==== bench/mf2_ref_model.svh ====
// Multiface Two reference model

`ifndef MF2_REF_MODEL_SVH
`define MF2_REF_MODEL_SVH

page_state_t ref_state;
logic        ref_hidden;
logic        ref_enabled;  // Mode other than disabled
logic [4:0]  ref_pen;
logic [3:0]  ref_crtc;
logic [7:0]  ref_mem [0:(1 << ram_aw) - 1];
bit          ref_known [0:(1 << ram_aw) - 1]; // Byte written at least once

// RAM keeps its contents over reset, so this runs once
task automatic forget_ram();
	foreach (ref_known[i])
		ref_known[i] = 1'b0;
endtask

task automatic reset_ref(input mf2_mode_t m);
	ref_state   = st_off;
	ref_hidden  = m != mode_enabled;
	ref_enabled = m != mode_disabled;
	ref_pen     = '0;
	ref_crtc    = '0;
endtask

task automatic write_ref(input logic [12:0] a, input logic [7:0] d);
	ref_mem[a]   = d;
	ref_known[a] = 1'b1;
endtask

// Port write to shadow byte, using the selects from earlier writes
task automatic shadow_target(input logic [15:0] a, input logic [7:0] d,
		output logic hit, output logic [12:0] target);
	hit    = 1'b1;
	target = '0;
	if (a[15:8] == 8'h7f) begin
		if (d[7:6] == 2'b00)
			target = sh_pen_index;
		else if (d[7:6] == 2'b10)
			target = sh_screen_mode;
		else if (d[7:6] == 2'b11)
			target = sh_banking;
		else if (ref_pen[4])
			target = sh_border;
		else
			target = sh_pen_base + {9'd0, ref_pen[3:0]};
	end else if (a[15:8] == 8'hbc)
		target = sh_crtc_select;
	else if (a[15:8] == 8'hbd)
		target = sh_crtc_base + {9'd0, ref_crtc};
	else if (a[15:8] == 8'hf7)
		target = sh_ppi;
	else if (a[15:8] == 8'hdf)
		target = sh_upper_rom;
	else
		hit = 1'b0;
endtask

task automatic apply_op(input bus_op_t op, input logic [15:0] a, input logic [7:0] d,
		output logic [7:0] exp_data, output logic exp_known, output logic exp_rom);
	logic        was_paged;
	logic        hit;
	logic [12:0] target;
	was_paged = ref_state == st_paged; // Paging as left by the previous operation
	exp_data  = open_bus;
	exp_known = 1'b1;
	exp_rom   = was_paged && a[15:13] == 3'b000;
	case (op)
		op_io_wr: begin
			if (a[15:2] == page_port[15:2]) begin
				if (!a[1] && !ref_hidden && ref_enabled)
					ref_state = st_paged;
				else
					ref_state = st_off;
			end else begin
				shadow_target(a, d, hit, target);
				if (hit)
					write_ref(target, d);
			end
			if (a[15:8] == 8'h7f && d[7:6] == 2'b00)
				ref_pen = d[4:0];
			if (a[15:8] == 8'hbc)
				ref_crtc = d[3:0];
		end
		op_mem_wr: if (was_paged && a[15:13] == 3'b001) write_ref(a[12:0], d);
		op_mem_rd: begin
			if (was_paged && a[15:13] == 3'b001) begin
				exp_data  = ref_mem[a[12:0]];
				exp_known = ref_known[a[12:0]];
			end
		end
		op_m1: begin
			if (a == nmi_entry && ref_state == st_nmi_pending) begin
				ref_state  = st_paged;
				ref_hidden = 1'b0;
			end else if (a == hide_entry && was_paged)
				ref_hidden = 1'b1;
		end
		default: if (ref_state == st_off && ref_enabled) ref_state = st_nmi_pending; // Key
	endcase
endtask

`endif

// ==== bench/tb_multiface_two.sv ====
// Multiface Two testbench

`timescale 1ns/1ps

module tb_multiface_two import mf2_pkg::*; ();

	localparam int clk_period     = 40;
	localparam int reset_cycles   = 8;
	localparam int n_random       = 500; // Operations in each of the three random streams
	localparam int n_directed     = 300; // Bound on directed operations and idles
	localparam int timeout_cycles = (3 * n_random + n_directed) * 4 + 4 * reset_cycles + 100;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        bus_stb;
	bus_op_t     bus_op;
	logic [15:0] bus_addr;
	logic [7:0]  bus_data;
	mf2_mode_t   mode;
	logic        nmi;
	logic        paged;
	logic        rd_valid;
	logic [7:0]  rd_data;
	logic        rd_rom;

	int    cyc = 0;
	int    fail_count;
	string test_name;

	// Expected results in issue order
	int         st_cyc_q[$];
	logic       st_nmi_q[$];
	logic       st_paged_q[$];
	int         rd_cyc_q[$];
	logic [7:0] rd_data_q[$];
	logic       rd_known_q[$];
	logic       rd_rom_q[$];

	`include "mf2_ref_model.svh"

	multiface_two u_multiface_two (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) cyc <= cyc + 1;

	////////////////////////////////////////
	// Checking

	task automatic fail_now(input string why);
		$display("%s in %s at cycle %0d", why, test_name, cyc);
		$display("Simulation finished: FAIL");
		$fatal(1, "Testbench stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			fail_count++;
			$display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
			fail_now("Wrong value");
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_sys) begin
		if (st_cyc_q.size() > 0 && st_cyc_q[0] == cyc) begin
			check_value("nmi", st_nmi_q[0], nmi);
			check_value("paged", st_paged_q[0], paged);
			void'(st_cyc_q.pop_front());
			void'(st_nmi_q.pop_front());
			void'(st_paged_q.pop_front());
		end
		if (rd_cyc_q.size() > 0 && rd_cyc_q[0] == cyc) begin
			if (rd_valid !== 1'b1)
				fail_now("Read result missing three cycles after its strobe");
			if (rd_known_q[0])
				check_value("rd_data", rd_data_q[0], rd_data);
			check_value("rd_rom", rd_rom_q[0], rd_rom);
			void'(rd_cyc_q.pop_front());
			void'(rd_data_q.pop_front());
			void'(rd_known_q.pop_front());
			void'(rd_rom_q.pop_front());
		end else if (rd_valid === 1'b1)
			fail_now("rd_valid high with no read outstanding");
	end

	initial begin
		repeat (timeout_cycles) @(posedge clk_sys);
		fail_now("Timeout, operations did not complete in time");
	end

	////////////////////////////////////////
	// Stimulus

	task automatic send_op(input bus_op_t op, input logic [15:0] a, input logic [7:0] d);
		logic [7:0] exp_data;
		logic       exp_known;
		logic       exp_rom;
		@(posedge clk_sys);
		#2;
		bus_stb  = 1'b1;
		bus_op   = op;
		bus_addr = a;
		bus_data = d;
		apply_op(op, a, d, exp_data, exp_known, exp_rom);
		st_cyc_q.push_back(cyc + 2);   // Paging follows two edges later
		st_nmi_q.push_back(ref_state == st_nmi_pending);
		st_paged_q.push_back(ref_state == st_paged);
		if (op == op_mem_rd) begin
			rd_cyc_q.push_back(cyc + 3);
			rd_data_q.push_back(exp_data);
			rd_known_q.push_back(exp_known);
			rd_rom_q.push_back(exp_rom);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_sys);
			#2;
			bus_stb = 1'b0;
		end
	endtask

	task automatic drain();
		idle(5);
		if (st_cyc_q.size() != 0 || rd_cyc_q.size() != 0)
			fail_now("Expected results left over after the pipeline emptied");
	endtask

	task automatic apply_reset(input mf2_mode_t m);
		@(posedge clk_sys);
		#2;
		reset   = 1'b1;
		mode    = m;
		bus_stb = 1'b0;
		repeat (reset_cycles) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		mode  = m == mode_disabled ? mode_enabled : mode_disabled; // Only sampled in reset
		reset_ref(m);
		check_value("nmi after reset", 0, nmi);
		check_value("paged after reset", 0, paged);
	endtask

	function automatic logic [15:0] store_port();
		case ($urandom_range(5))
			0, 1: return {8'h7f, 8'($urandom)}; // Gate array
			2: return {8'hbc, 8'($urandom)};
			3: return {8'hbd, 8'($urandom)};
			4: return {8'hf7, 8'($urandom)};
			default: return {8'hdf, 8'($urandom)};
		endcase
	endfunction

	function automatic logic [15:0] window_addr();
		case ($urandom_range(2))
			0: return 16'h2000 + 16'($urandom_range(31));
			1: return 16'h3f80 + 16'($urandom_range(127)); // Shadow area
			default: return {3'b001, 13'($urandom)};
		endcase
	endfunction

	task automatic random_op();
		int unsigned pick;
		logic [7:0]  d;
		pick = $urandom_range(99);
		d    = 8'($urandom);
		if (pick < 24)
			send_op(op_io_wr, store_port(), d);
		else if (pick < 30)
			send_op(op_io_wr, pick < 27 ? {page_port[15:2], 2'($urandom)} : 16'($urandom), d);
		else if (pick < 48)
			send_op(op_mem_wr, window_addr(), d);
		else if (pick < 64)
			send_op(op_mem_rd, window_addr(), d);
		else if (pick < 75)
			send_op(op_mem_rd, pick < 70 ? {3'b000, 13'($urandom)} : 16'($urandom), d);
		else if (pick < 93)
			send_op(op_m1, pick < 81 ? nmi_entry : pick < 87 ? hide_entry : 16'($urandom), d);
		else
			send_op(op_key_nmi, 16'($urandom), d);
		if ($urandom_range(4) == 0)
			idle(1); // Mostly back to back
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		logic [15:0] a;
		logic [15:0] win_addrs[$];
		bus_stb    = 1'b0;
		bus_op     = op_io_wr;
		bus_addr   = '0;
		bus_data   = '0;
		mode       = mode_enabled;
		reset      = 1'b1;
		fail_count = 0;
		test_name  = "reset";
		void'($urandom(25679));
		forget_ram();

		apply_reset(mode_enabled);
		send_op(op_mem_rd, 16'h2000, 8'h00); // Open bus while not paged
		send_op(op_mem_rd, 16'h0100, 8'h00);
		drain();

		test_name = "freeze";
		send_op(op_key_nmi, 16'h0000, 8'h00);
		idle(2);
		send_op(op_m1, nmi_entry, 8'h00);
		send_op(op_mem_rd, 16'h0066, 8'h00); // ROM flag once paged
		drain();

		// Every pen and CRTC register is written and read back after page-in
		test_name = "shadow";
		send_op(op_io_wr, 16'hfeea, 8'h00);
		for (int i = 0; i < 17; i++) begin
			send_op(op_io_wr, 16'h7f00, {3'b000, 5'(i)});
			send_op(op_io_wr, 16'h7f00, {2'b01, 6'($urandom)});
		end
		for (int i = 0; i < 16; i++) begin
			send_op(op_io_wr, 16'hbc00, 8'(i));
			send_op(op_io_wr, 16'hbd00, 8'($urandom));
		end
		send_op(op_io_wr, 16'h7f00, {2'b10, 6'($urandom)});
		send_op(op_io_wr, 16'h7f00, {2'b11, 6'($urandom)});
		send_op(op_io_wr, 16'hf782, 8'($urandom));
		send_op(op_io_wr, 16'hdf00, 8'($urandom));
		send_op(op_key_nmi, 16'h0000, 8'h00);
		send_op(op_m1, nmi_entry, 8'h00);
		for (int i = 0; i < 16; i++) begin
			send_op(op_mem_rd, {3'b001, sh_pen_base + 13'(i)}, 8'h00);
			send_op(op_mem_rd, {3'b001, sh_crtc_base + 13'(i)}, 8'h00);
		end
		send_op(op_mem_rd, {3'b001, sh_pen_index}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_border}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_screen_mode}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_banking}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_crtc_select}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_ppi}, 8'h00);
		send_op(op_mem_rd, {3'b001, sh_upper_rom}, 8'h00);
		drain();

		test_name = "window";
		repeat (32) begin
			a = window_addr();
			win_addrs.push_back(a);
			send_op(op_mem_wr, a, 8'($urandom));
			send_op(op_mem_rd, a, 8'h00);
		end
		repeat (8) send_op(op_mem_rd, {3'b000, 13'($urandom)}, 8'h00);
		send_op(op_io_wr, 16'hfeea, 8'h00);
		for (int i = 0; i < 16; i++) begin
			send_op(op_mem_wr, win_addrs[i], 8'($urandom)); // Ignored while not paged
			send_op(op_mem_rd, win_addrs[i], 8'h00);
		end
		send_op(op_io_wr, 16'hfee8, 8'h00);
		for (int i = 0; i < 16; i++)
			send_op(op_mem_rd, win_addrs[i], 8'h00); // Data from the paged writes
		drain();

		test_name = "hide";
		send_op(op_io_wr, 16'hfee8, 8'h00);
		send_op(op_m1, hide_entry, 8'h00);
		send_op(op_io_wr, 16'hfeea, 8'h00);
		send_op(op_io_wr, 16'hfee8, 8'h00);
		drain();

		test_name = "random";
		repeat (n_random) random_op();
		drain();

		apply_reset(mode_disabled);
		test_name = "disabled";
		send_op(op_key_nmi, 16'h0000, 8'h00);
		send_op(op_io_wr, 16'hfee8, 8'h00);
		repeat (n_random) random_op();
		drain();

		apply_reset(mode_hidden);
		test_name = "hidden";
		send_op(op_io_wr, 16'hfee8, 8'h00);
		send_op(op_key_nmi, 16'h0000, 8'h00);
		send_op(op_m1, nmi_entry, 8'h00);
		repeat (n_random) random_op();
		drain();

		if (fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== rtl/mf2_control.sv ====
// Multiface Two paging control

`timescale 1ns/1ps

module mf2_control import mf2_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,
	input  mf2_mode_t         mode,

	input  logic              dec_valid,
	input  bus_op_t           dec_op,
	input  logic [addr_w-1:0] dec_addr,
	input  logic [data_w-1:0] dec_data,
	input  logic              dec_store,
	input  logic [ram_aw-1:0] dec_store_addr,
	input  logic              dec_page_port,
	input  logic              dec_nmi_fetch,
	input  logic              dec_hide_fetch,
	input  logic              dec_ram_win,
	input  logic              dec_rom_win,

	output logic              nmi,
	output logic              paged,
	output ram_cmd_t          ram_cmd,
	output logic [ram_aw-1:0] ram_addr,
	output logic [data_w-1:0] ram_wdata,
	output logic              ram_rom,
	output logic              ram_hit
);

	page_state_t state;
	mf2_mode_t   mode_q;  // Mode as taken at reset
	logic        hidden;
	logic        enabled;
	logic        win_wr;

	assign enabled = mode_q != mode_disabled;
	assign nmi     = state == st_nmi_pending;
	assign paged   = state == st_paged;

	////////////////////////////////////////
	// Freeze and paging FSM

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= st_off;
			mode_q <= mode;
			hidden <= mode != mode_enabled;
		end else if (dec_valid) begin
			if (dec_page_port) begin
				// FEE8h pages in unless hidden, FEEAh always pages out
				if (!dec_addr[1] && !hidden && enabled)
					state <= st_paged;
				else
					state <= st_off;
			end else if (dec_op == op_key_nmi) begin
				if (state == st_off && enabled)
					state <= st_nmi_pending;
			end else if (dec_nmi_fetch && state == st_nmi_pending) begin
				state  <= st_paged;
				hidden <= 1'b0; // Freeze makes the interface visible again
			end else if (dec_hide_fetch && paged) begin
				hidden <= 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// RAM command

	assign win_wr = dec_op == op_mem_wr && dec_ram_win && paged;

	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_cmd <= cmd_none;
		else if (dec_valid && (dec_store || win_wr))
			ram_cmd <= cmd_write;
		else if (dec_valid && dec_op == op_mem_rd)
			ram_cmd <= cmd_read;
		else
			ram_cmd <= cmd_none;
	end

	always_ff @(posedge clk_sys) begin
		ram_addr  <= dec_store ? dec_store_addr : dec_addr[ram_aw-1:0];
		ram_wdata <= dec_data;
		ram_rom   <= paged && dec_rom_win;
		ram_hit   <= paged && dec_ram_win; // Reads outside the window see open bus
	end

	a_nmi_not_paged: assert property (@(posedge clk_sys) disable iff (reset)
		!(nmi && paged));

endmodule

// ==== rtl/mf2_decode.sv ====
// Multiface Two port decode

`timescale 1ns/1ps

module mf2_decode import mf2_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              bus_stb,
	input  bus_op_t           bus_op,
	input  logic [addr_w-1:0] bus_addr,
	input  logic [data_w-1:0] bus_data,

	output logic              dec_valid,
	output bus_op_t           dec_op,
	output logic [addr_w-1:0] dec_addr,
	output logic [data_w-1:0] dec_data,
	output logic              dec_store,
	output logic [ram_aw-1:0] dec_store_addr,
	output logic              dec_page_port,
	output logic              dec_nmi_fetch,
	output logic              dec_hide_fetch,
	output logic              dec_ram_win,
	output logic              dec_rom_win
);

	logic [4:0]        pen_index;     // Last gate array pen select
	logic [3:0]        crtc_reg;      // Last CRTC register select
	logic              io_wr;
	logic              page_hit;
	logic              store_hit;
	logic [ram_aw-1:0] store_addr;

	assign io_wr    = bus_stb && bus_op == op_io_wr;
	assign page_hit = bus_addr[15:2] == page_port[15:2];

	////////////////////////////////////////
	// Shadow address map

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (bus_addr[15:8])
			8'h7f: begin // Gate array, function in data bits 7:6
				case (bus_data[7:6])
					2'b00: store_addr = sh_pen_index;
					2'b01: store_addr = pen_index[4] ? sh_border
						: sh_pen_base + ram_aw'(pen_index[3:0]);
					2'b10: store_addr = sh_screen_mode;
					default: store_addr = sh_banking;
				endcase
			end
			8'hbc: store_addr = sh_crtc_select;
			8'hbd: store_addr = sh_crtc_base + ram_aw'(crtc_reg);
			8'hf7: store_addr = sh_ppi;      // 8255
			8'hdf: store_addr = sh_upper_rom;
			default: store_hit = 1'b0;
		endcase
	end

	// Register selects that later data writes refer to
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pen_index <= '0;
			crtc_reg  <= '0;
		end else if (io_wr) begin
			if (bus_addr[15:8] == 8'h7f && bus_data[7:6] == 2'b00)
				pen_index <= bus_data[4:0];
			if (bus_addr[15:8] == 8'hbc)
				crtc_reg <= bus_data[3:0];
		end
	end

	////////////////////////////////////////
	// Output stage

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dec_valid      <= 1'b0;
			dec_store      <= 1'b0;
			dec_page_port  <= 1'b0;
			dec_nmi_fetch  <= 1'b0;
			dec_hide_fetch <= 1'b0;
		end else begin
			dec_valid      <= bus_stb;
			dec_page_port  <= io_wr && page_hit;
			dec_store      <= io_wr && store_hit && !page_hit; // Page port wins
			dec_nmi_fetch  <= bus_stb && bus_op == op_m1 && bus_addr == nmi_entry;
			dec_hide_fetch <= bus_stb && bus_op == op_m1 && bus_addr == hide_entry;
		end
	end

	always_ff @(posedge clk_sys) begin
		dec_op         <= bus_op;
		dec_addr       <= bus_addr;
		dec_data       <= bus_data;
		dec_store_addr <= store_addr;
		dec_ram_win    <= bus_addr[15:13] == 3'b001; // 2000h-3FFFh
		dec_rom_win    <= bus_addr[15:13] == 3'b000; // 0000h-1FFFh
	end

	// A port write is either a page request or a shadow store
	a_store_xor_page: assert property (@(posedge clk_sys) disable iff (reset)
		!(dec_store && dec_page_port));

endmodule

// ==== rtl/mf2_pkg.sv ====
// Multiface Two definitions

package mf2_pkg;

	////////////////////////////////////////
	// Widths

	localparam int addr_w = 16; // CPU address
	localparam int data_w = 8;  // Data byte
	localparam int ram_aw = 13; // 8 KB shadow RAM

	////////////////////////////////////////
	// Bus operations and states

	typedef enum logic [2:0] {
		op_io_wr,   // OUT to a port
		op_mem_wr,
		op_mem_rd,
		op_m1,      // Opcode fetch
		op_key_nmi  // Freeze button
	} bus_op_t;

	typedef enum logic [1:0] {
		mode_enabled,
		mode_hidden,
		mode_disabled
	} mf2_mode_t;

	typedef enum logic [1:0] {
		st_off,
		st_nmi_pending, // NMI raised, waiting for the 0066h fetch
		st_paged
	} page_state_t;

	typedef enum logic [1:0] {
		cmd_none,
		cmd_write,
		cmd_read
	} ram_cmd_t;

	////////////////////////////////////////
	// Shadow copies of write-only hardware registers

	localparam logic [ram_aw-1:0] sh_pen_index   = 13'h1fcf;
	localparam logic [ram_aw-1:0] sh_pen_base    = 13'h1f90; // 16 pen colours
	localparam logic [ram_aw-1:0] sh_border      = 13'h1fdf;
	localparam logic [ram_aw-1:0] sh_screen_mode = 13'h1fef;
	localparam logic [ram_aw-1:0] sh_banking     = 13'h1fff;
	localparam logic [ram_aw-1:0] sh_crtc_select = 13'h1cff;
	localparam logic [ram_aw-1:0] sh_crtc_base   = 13'h1db0; // 16 CRTC registers
	localparam logic [ram_aw-1:0] sh_ppi         = 13'h17ff;
	localparam logic [ram_aw-1:0] sh_upper_rom   = 13'h1aac;

	// Entry points seen on M1
	localparam logic [addr_w-1:0] nmi_entry  = 16'h0066;
	localparam logic [addr_w-1:0] hide_entry = 16'h0065;

	// FEE8h pages in, FEEAh pages out; only bits 15:2 are decoded
	localparam logic [addr_w-1:0] page_port = 16'hfee8;

	localparam logic [data_w-1:0] open_bus = 8'hff;

endpackage

// ==== rtl/mf2_ram.sv ====
// Multiface Two shadow RAM

`timescale 1ns/1ps

module mf2_ram import mf2_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,

	input  ram_cmd_t          ram_cmd,
	input  logic [ram_aw-1:0] ram_addr,
	input  logic [data_w-1:0] ram_wdata,
	input  logic              ram_rom,
	input  logic              ram_hit,

	output logic              rd_valid,
	output logic [data_w-1:0] rd_data,
	output logic              rd_rom
);

	logic [data_w-1:0] mem [0:(1 << ram_aw) - 1]; // 8192 x 8

	////////////////////////////////////////
	// Array and read port

	always_ff @(posedge clk_sys) begin
		if (ram_cmd == cmd_write)
			mem[ram_addr] <= ram_wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (ram_cmd == cmd_read) begin
			rd_data <= ram_hit ? mem[ram_addr] : open_bus;
			rd_rom  <= ram_rom; // ROM image not held here, flag only
		end
	end

	// One-cycle result strobe
	always_ff @(posedge clk_sys) begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= ram_cmd == cmd_read;
	end

	// Store and window addresses come from registered decode
	a_wr_addr_known: assert property (@(posedge clk_sys) disable iff (reset)
		ram_cmd == cmd_write |-> !$isunknown(ram_addr));

endmodule

// ==== rtl/multiface_two.sv ====
// Multiface Two top level

`timescale 1ns/1ps

module multiface_two import mf2_pkg::*; (
	input  logic              clk_sys,
	input  logic              reset,

	input  logic              bus_stb,
	input  bus_op_t           bus_op,
	input  logic [addr_w-1:0] bus_addr,
	input  logic [data_w-1:0] bus_data,
	input  mf2_mode_t         mode,     // Sampled during reset

	output logic              nmi,
	output logic              paged,
	output logic              rd_valid,
	output logic [data_w-1:0] rd_data,
	output logic              rd_rom
);

	////////////////////////////////////////
	// Decode to control

	logic              dec_valid;
	bus_op_t           dec_op;
	logic [addr_w-1:0] dec_addr;
	logic [data_w-1:0] dec_data;
	logic              dec_store;
	logic [ram_aw-1:0] dec_store_addr;
	logic              dec_page_port;
	logic              dec_nmi_fetch;
	logic              dec_hide_fetch;
	logic              dec_ram_win;
	logic              dec_rom_win;

	// Control to RAM
	ram_cmd_t          ram_cmd;
	logic [ram_aw-1:0] ram_addr;
	logic [data_w-1:0] ram_wdata;
	logic              ram_rom;
	logic              ram_hit;

	mf2_decode u_decode (.*);

	mf2_control u_control (.*);

	mf2_ram u_ram (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ram_cmd   (ram_cmd),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rom   (ram_rom),
		.ram_hit   (ram_hit),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data),
		.rd_rom    (rd_rom)
	);

endmodule

// ==== sim.f ====
+incdir+bench
rtl/mf2_pkg.sv
rtl/mf2_decode.sv
rtl/mf2_control.sv
rtl/mf2_ram.sv
rtl/multiface_two.sv
bench/tb_multiface_two.sv
